/* compile.f */
+incdir+src
src/spi_pkg.sv
src/sync_fifo.sv
src/spi_clk_gen.sv
src/spi_frame_ctrl.sv
src/axil_regs.sv
src/spi_master_top.sv
sim/tb_clk_gen.sv
sim/spi_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= spi_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FILELIST)) src/spi_macros.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/spi_tb.sv */
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_tb;
    localparam int PM          = 2;
    localparam int MAX_CHARS   = 8;
    localparam int NUM_FRAMES  = 8;
    // slowest frame plus word gaps and finish, in ns
    localparam int FRAME_NS    = (MAX_CHARS * 16 * (PM + 1) + 64) * 4;
    localparam int WATCHDOG_NS = FRAME_NS * NUM_FRAMES + 20000;
    localparam int POLL_LIMIT  = 400;
    localparam int HS_LIMIT    = 20;

    logic               S_SYSCLK;
    logic               S_RESETN;
    spi_pkg::reg_addr_t awaddr;
    logic               awvalid;
    logic               awready;
    spi_pkg::reg_word_t wdata;
    logic [3:0]         wstrb;
    logic               wvalid;
    logic               wready;
    logic               bvalid;
    logic               bready;
    logic [1:0]         bresp;
    spi_pkg::reg_addr_t araddr;
    logic               arvalid;
    logic               arready;
    spi_pkg::reg_word_t rdata;
    logic               rvalid;
    logic               rready;
    logic [1:0]         rresp;
    logic               miso;
    logic               sck;
    logic               mosi;
    logic [`SPI_NCS-1:0] sel;
    logic               irq;

    logic               sck_prev;
    spi_pkg::reg_word_t mosi_cap;  // last 32 bits seen on mosi

    int     errors;
    int     checks;
    int     err_base;
    string  cur_test;
    integer seed;

    tb_clk_gen #(.PERIOD_NS(4), .RESET_CYCLES(8)) u_clk_gen (
        .clk_o   (S_SYSCLK),
        .rst_n_o (S_RESETN)
    );

    spi_master_top spi_master_top_inst (
        .S_SYSCLK    (S_SYSCLK),
        .S_RESETN    (S_RESETN),
        .s_awaddr_i  (awaddr),
        .s_awvalid_i (awvalid),
        .s_awready_o (awready),
        .s_wdata_i   (wdata),
        .s_wstrb_i   (wstrb),
        .s_wvalid_i  (wvalid),
        .s_wready_o  (wready),
        .s_bvalid_o  (bvalid),
        .s_bready_i  (bready),
        .s_bresp_o   (bresp),
        .s_araddr_i  (araddr),
        .s_arvalid_i (arvalid),
        .s_arready_o (arready),
        .s_rdata_o   (rdata),
        .s_rvalid_o  (rvalid),
        .s_rready_i  (rready),
        .s_rresp_o   (rresp),
        .spi_miso_i  (miso),
        .spi_sck_o   (sck),
        .spi_mosi_o  (mosi),
        .spi_sel_o   (sel),
        .irq_o       (irq)
    );

    // mosi bits on each rising sck
    always @(negedge S_SYSCLK) begin
        if (sck && !sck_prev) begin
            mosi_cap <= {mosi_cap[30:0], mosi};
        end
        sck_prev <= sck;
    end

    task automatic check_word(input string what, input spi_pkg::reg_word_t exp,
                              input spi_pkg::reg_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s, %s: expected 0x%h, actual 0x%h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_char(input string what, input spi_pkg::spi_char_t exp,
                              input spi_pkg::spi_char_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s, %s: expected 0x%h, actual 0x%h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s, %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic report_fault(input string msg);
        errors++;
        $display("%s: %s", cur_test, msg);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_base = errors;
    endtask

    task automatic end_test();
        if (errors == err_base) begin
            $display("test %s: pass", cur_test);
        end else begin
            $display("test %s: FAIL with %0d bad checks", cur_test, errors - err_base);
        end
    endtask

    // bus tasks start and end on a falling edge
    task automatic axi_write(input spi_pkg::reg_addr_t addr, input spi_pkg::reg_word_t data);
        int n;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        while (!bvalid && n < HS_LIMIT) begin
            @(negedge S_SYSCLK);
            n++;
        end
        if (!bvalid) begin
            report_fault("write response never arrived");
        end else if (bresp != 2'b00) begin
            report_fault("write response was not OKAY");
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        @(negedge S_SYSCLK);
        bready  = 1'b0;
    endtask

    task automatic axi_read(input spi_pkg::reg_addr_t addr, output spi_pkg::reg_word_t data);
        int n;
        araddr  = addr;
        arvalid = 1'b1;
        check_bit("arready with no read pending", 1'b1, arready);
        n = 0;
        while (!rvalid && n < HS_LIMIT) begin
            @(negedge S_SYSCLK);
            n++;
        end
        if (!rvalid) begin
            report_fault("read data never arrived");
        end else if (rresp != 2'b00) begin
            report_fault("read response was not OKAY");
        end
        data    = rdata;
        arvalid = 1'b0;
        rready  = 1'b1;
        @(negedge S_SYSCLK);
        rready  = 1'b0;
    endtask

    function automatic spi_pkg::reg_word_t mode_word(input logic loop, input logic cpol,
                                                    input logic cpha);
        spi_pkg::reg_word_t m;
        m = '0;
        m[`SPMODE_EN]   = 1'b1;
        m[`SPMODE_LOOP] = loop;
        m[`SPMODE_CPOL] = cpol;
        m[`SPMODE_CPHA] = cpha;
        m[`SPMODE_PM_HI:`SPMODE_PM_LO] = 8'(PM);
        return m;
    endfunction

    task automatic start_frame(input spi_pkg::cs_idx_t cs, input spi_pkg::xfer_len_t len);
        axi_write(`SPI_ADDR_SPIE, 32'h1 << `SPIE_DON);  // clear stale done
        axi_write(`SPI_ADDR_SPCOM, {cs, 14'h0, len});
    endtask

    task automatic wait_done();
        spi_pkg::reg_word_t v;
        int n;
        v = '0;
        n = 0;
        while (!v[`SPIE_DON] && n < POLL_LIMIT) begin
            axi_read(`SPI_ADDR_SPIE, v);
            n++;
        end
        if (!v[`SPIE_DON]) begin
            report_fault("frame never signalled done");
        end
    endtask

    task automatic registers_reset_and_rw();
        spi_pkg::reg_word_t v;
        begin_test("registers");
        axi_read(`SPI_ADDR_SPMODE, v);
        check_word("SPMODE reset", 32'h0, v);
        axi_read(`SPI_ADDR_SPIM, v);
        check_word("SPIM reset", 32'h0, v);
        axi_read(`SPI_ADDR_SPIE, v);
        check_word("SPIE reset", 32'h1 << `SPIE_TNF, v);
        axi_write(`SPI_ADDR_SPMODE, 32'h0000_5A0A);  // enable left off
        axi_read(`SPI_ADDR_SPMODE, v);
        check_word("SPMODE readback", 32'h0000_5A0A, v);
        axi_write(`SPI_ADDR_SPIM, 32'h0000_0006);
        axi_read(`SPI_ADDR_SPIM, v);
        check_word("SPIM readback", 32'h0000_0006, v);
        axi_write(`SPI_ADDR_SPIM, 32'h0);
        axi_read(8'h1C, v);
        check_word("unmapped read", 32'h0, v);
        check_word("select lines", 32'hf, 32'(sel));
        end_test();
    endtask

    task automatic loopback_frame();
        spi_pkg::reg_word_t word;
        spi_pkg::reg_word_t v;
        int i;
        begin_test("loopback");
        word = $random(seed);
        axi_write(`SPI_ADDR_SPMODE, mode_word(1'b1, 1'b0, 1'b0));
        axi_write(`SPI_ADDR_SPITF, word);
        start_frame(2'd2, 16'd3);
        wait_done();
        for (i = 0; i < 4; i++) begin
            axi_read(`SPI_ADDR_SPIRF, v);
            check_char("received char", word[8*i +: 8], v[7:0]);
        end
        axi_read(`SPI_ADDR_SPIRF, v);
        check_word("read of empty rx fifo", 32'h0, v);
        axi_read(`SPI_ADDR_SPIE, v);
        check_bit("RNE after drain", 1'b0, v[`SPIE_RNE]);
        end_test();
    endtask

    task automatic select_and_miso();
        spi_pkg::reg_word_t v;
        spi_pkg::reg_word_t word;
        spi_pkg::cs_idx_t   cs;
        int k;
        int i;
        begin_test("select and miso");
        axi_write(`SPI_ADDR_SPMODE, mode_word(1'b0, 1'b0, 1'b0));
        for (k = 0; k < 2; k++) begin
            miso = (k == 0);
            cs   = (k == 0) ? 2'd1 : 2'd3;
            word = $random(seed);
            axi_write(`SPI_ADDR_SPITF, word);
            start_frame(cs, 16'd3);
            check_word("select during frame", 32'hf & ~(32'h1 << cs), 32'(sel));
            wait_done();
            check_word("select after frame", 32'hf, 32'(sel));
            // msb first, low byte goes out first
            check_word("mosi bits", {word[7:0], word[15:8], word[23:16], word[31:24]},
                       mosi_cap);
            for (i = 0; i < 4; i++) begin
                axi_read(`SPI_ADDR_SPIRF, v);
                check_char("miso char", (k == 0) ? 8'hff : 8'h00, v[7:0]);
            end
        end
        miso = 1'b0;
        end_test();
    endtask

    task automatic cpol_cpha_modes();
        logic [63:0]        pair;
        spi_pkg::reg_word_t v;
        logic               cpol;
        logic               cpha;
        int m;
        int i;
        begin_test("modes");
        for (m = 0; m < 4; m++) begin
            cpol = m[0];
            cpha = m[1];
            axi_write(`SPI_ADDR_SPMODE, mode_word(1'b1, cpol, cpha));
            check_bit("sck idle level", cpol, sck);
            pair[31:0]  = $random(seed);
            pair[63:32] = $random(seed);
            axi_write(`SPI_ADDR_SPITF, pair[31:0]);
            axi_write(`SPI_ADDR_SPITF, pair[63:32]);
            start_frame(2'd0, 16'd7);
            wait_done();
            for (i = 0; i < 8; i++) begin
                axi_read(`SPI_ADDR_SPIRF, v);
                check_char("mode char", pair[8*i +: 8], v[7:0]);
            end
            check_bit("sck idle after frame", cpol, sck);
        end
        end_test();
    endtask

    task automatic interrupt_mask();
        spi_pkg::reg_word_t v;
        int i;
        begin_test("interrupt");
        axi_write(`SPI_ADDR_SPIM, 32'h0);
        axi_write(`SPI_ADDR_SPMODE, mode_word(1'b1, 1'b0, 1'b0));
        axi_write(`SPI_ADDR_SPITF, $random(seed));
        start_frame(2'd0, 16'd3);
        wait_done();
        check_bit("irq with mask clear", 1'b0, irq);
        for (i = 0; i < 4; i++) begin
            axi_read(`SPI_ADDR_SPIRF, v);
        end
        axi_write(`SPI_ADDR_SPIM, 32'h1 << `SPIE_DON);
        check_bit("irq with done unmasked", 1'b1, irq);
        axi_write(`SPI_ADDR_SPIE, 32'h1 << `SPIE_DON);
        check_bit("irq after done cleared", 1'b0, irq);
        end_test();
    endtask

    task automatic write_backpressure();
        spi_pkg::reg_word_t a;
        spi_pkg::reg_word_t b;
        spi_pkg::reg_word_t v;
        int n;
        begin_test("back-pressure");
        a = $random(seed);
        b = $random(seed) & ~32'h1;  // keep controller disabled
        awaddr  = `SPI_ADDR_SPIM;
        wdata   = a;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge S_SYSCLK);
        check_bit("bvalid after first write", 1'b1, bvalid);
        awaddr = `SPI_ADDR_SPMODE;  // second write queued behind it
        wdata  = b;
        repeat (3) begin
            @(negedge S_SYSCLK);
            check_bit("bvalid held", 1'b1, bvalid);
            check_bit("awready with response pending", 1'b0, awready);
            check_bit("wready with response pending", 1'b0, wready);
        end
        bready = 1'b1;
        @(negedge S_SYSCLK);
        check_bit("awready after response taken", 1'b1, awready);
        check_bit("wready after response taken", 1'b1, wready);
        n = 0;
        while (!bvalid && n < HS_LIMIT) begin
            @(negedge S_SYSCLK);
            n++;
        end
        if (!bvalid) begin
            report_fault("second write was never accepted");
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge S_SYSCLK);
        bready = 1'b0;
        axi_read(`SPI_ADDR_SPIM, v);
        check_word("first write readback", a, v);
        axi_read(`SPI_ADDR_SPMODE, v);
        check_word("second write readback", b, v);
        end_test();
    endtask

    initial begin
        seed     = 32'h1723;
        errors   = 0;
        checks   = 0;
        err_base = 0;
        cur_test = "reset";
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = 4'hf;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        miso     = 1'b0;
        @(posedge S_RESETN);
        @(negedge S_SYSCLK);
        registers_reset_and_rw();
        loopback_frame();
        select_and_miso();
        cpol_cpha_modes();
        interrupt_mask();
        write_backpressure();
        $display("checks: %0d, failed: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // limit from frame count and length
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run exceeded %0d ns in test %s", WATCHDOG_NS, cur_test);
        $display("Errors found");
        $finish;
    end

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);  // release away from the active edge
        rst_n_o = 1'b1;
    end

endmodule

/* src/spi_master_top.sv */
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_master_top (
    input  logic                S_SYSCLK,
    input  logic                S_RESETN,
    input  spi_pkg::reg_addr_t  s_awaddr_i,
    input  logic                s_awvalid_i,
    output logic                s_awready_o,
    input  spi_pkg::reg_word_t  s_wdata_i,
    input  logic [3:0]          s_wstrb_i,
    input  logic                s_wvalid_i,
    output logic                s_wready_o,
    output logic                s_bvalid_o,
    input  logic                s_bready_i,
    output logic [1:0]          s_bresp_o,
    input  spi_pkg::reg_addr_t  s_araddr_i,
    input  logic                s_arvalid_i,
    output logic                s_arready_o,
    output spi_pkg::reg_word_t  s_rdata_o,
    output logic                s_rvalid_o,
    input  logic                s_rready_i,
    output logic [1:0]          s_rresp_o,
    input  logic                spi_miso_i,
    output logic                spi_sck_o,
    output logic                spi_mosi_o,
    output logic [`SPI_NCS-1:0] spi_sel_o,
    output logic                irq_o
);
    spi_pkg::reg_word_t spmode;
    spi_pkg::reg_word_t spcom;
    spi_pkg::reg_word_t txf_wdata;
    spi_pkg::reg_word_t txf_rdata;
    spi_pkg::spi_char_t rxf_wdata;
    spi_pkg::spi_char_t rxf_rdata;
    logic               frame_start;
    logic               frame_busy;
    logic               frame_done;
    logic               txf_push;
    logic               txf_pop;
    logic               txf_full;
    logic               txf_empty;
    logic               rxf_push;
    logic               rxf_pop;
    logic               rxf_empty;
    logic               sck_run;
    logic               lead_edge;
    logic               trail_edge;

    axil_regs u_regs (
        .S_SYSCLK      (S_SYSCLK),
        .S_RESETN      (S_RESETN),
        .s_awaddr_i    (s_awaddr_i),
        .s_awvalid_i   (s_awvalid_i),
        .s_awready_o   (s_awready_o),
        .s_wdata_i     (s_wdata_i),
        .s_wstrb_i     (s_wstrb_i),
        .s_wvalid_i    (s_wvalid_i),
        .s_wready_o    (s_wready_o),
        .s_bvalid_o    (s_bvalid_o),
        .s_bready_i    (s_bready_i),
        .s_bresp_o     (s_bresp_o),
        .s_araddr_i    (s_araddr_i),
        .s_arvalid_i   (s_arvalid_i),
        .s_arready_o   (s_arready_o),
        .s_rdata_o     (s_rdata_o),
        .s_rvalid_o    (s_rvalid_o),
        .s_rready_i    (s_rready_i),
        .s_rresp_o     (s_rresp_o),
        .frame_busy_i  (frame_busy),
        .frame_done_i  (frame_done),
        .txf_full_i    (txf_full),
        .rxf_empty_i   (rxf_empty),
        .rxf_data_i    (rxf_rdata),
        .spmode_o      (spmode),
        .spcom_o       (spcom),
        .frame_start_o (frame_start),
        .txf_push_o    (txf_push),
        .txf_data_o    (txf_wdata),
        .rxf_pop_o     (rxf_pop),
        .irq_o         (irq_o)
    );

    // tx side holds whole words
    sync_fifo #(
        .DEPTH (`SPI_TXFIFO_DEPTH),
        .T     (spi_pkg::reg_word_t)
    ) u_txf (
        .S_SYSCLK (S_SYSCLK),
        .S_RESETN (S_RESETN),
        .push_i   (txf_push),
        .data_i   (txf_wdata),
        .pop_i    (txf_pop),
        .data_o   (txf_rdata),
        .full_o   (txf_full),
        .empty_o  (txf_empty)
    );

    sync_fifo #(
        .DEPTH (`SPI_RXFIFO_DEPTH),
        .T     (spi_pkg::spi_char_t)
    ) u_rxf (
        .S_SYSCLK (S_SYSCLK),
        .S_RESETN (S_RESETN),
        .push_i   (rxf_push),
        .data_i   (rxf_wdata),
        .pop_i    (rxf_pop),
        .data_o   (rxf_rdata),
        .full_o   (),
        .empty_o  (rxf_empty)
    );

    spi_clk_gen u_clk (
        .S_SYSCLK     (S_SYSCLK),
        .S_RESETN     (S_RESETN),
        .run_i        (sck_run),
        .cpol_i       (spmode[`SPMODE_CPOL]),
        .prescale_i   (spmode[`SPMODE_PM_HI:`SPMODE_PM_LO]),
        .sck_o        (spi_sck_o),
        .lead_edge_o  (lead_edge),
        .trail_edge_o (trail_edge)
    );

    spi_frame_ctrl u_frame (
        .S_SYSCLK     (S_SYSCLK),
        .S_RESETN     (S_RESETN),
        .start_i      (frame_start),
        .cpha_i       (spmode[`SPMODE_CPHA]),
        .loop_i       (spmode[`SPMODE_LOOP]),
        .cs_idx_i     (spcom[`SPCOM_CS_HI:`SPCOM_CS_LO]),
        .tranlen_i    (spcom[`SPCOM_TRANLEN_HI:`SPCOM_TRANLEN_LO]),
        .txf_data_i   (txf_rdata),
        .txf_empty_i  (txf_empty),
        .lead_edge_i  (lead_edge),
        .trail_edge_i (trail_edge),
        .miso_i       (spi_miso_i),
        .busy_o       (frame_busy),
        .done_o       (frame_done),
        .txf_pop_o    (txf_pop),
        .rxf_push_o   (rxf_push),
        .rxf_data_o   (rxf_wdata),
        .sck_run_o    (sck_run),
        .mosi_o       (spi_mosi_o),
        .sel_o        (spi_sel_o)
    );

endmodule

/* src/axil_regs.sv */
`timescale 1ns/1ps
`include "spi_macros.svh"

module axil_regs (
    input  logic               S_SYSCLK,
    input  logic               S_RESETN,
    input  spi_pkg::reg_addr_t s_awaddr_i,
    input  logic               s_awvalid_i,
    output logic               s_awready_o,
    input  spi_pkg::reg_word_t s_wdata_i,
    input  logic [3:0]         s_wstrb_i,
    input  logic               s_wvalid_i,
    output logic               s_wready_o,
    output logic               s_bvalid_o,
    input  logic               s_bready_i,
    output logic [1:0]         s_bresp_o,
    input  spi_pkg::reg_addr_t s_araddr_i,
    input  logic               s_arvalid_i,
    output logic               s_arready_o,
    output spi_pkg::reg_word_t s_rdata_o,
    output logic               s_rvalid_o,
    input  logic               s_rready_i,
    output logic [1:0]         s_rresp_o,
    input  logic               frame_busy_i,
    input  logic               frame_done_i,
    input  logic               txf_full_i,
    input  logic               rxf_empty_i,
    input  spi_pkg::spi_char_t rxf_data_i,
    output spi_pkg::reg_word_t spmode_o,
    output spi_pkg::reg_word_t spcom_o,
    output logic               frame_start_o,
    output logic               txf_push_o,
    output spi_pkg::reg_word_t txf_data_o,
    output logic               rxf_pop_o,
    output logic               irq_o
);
    spi_pkg::reg_word_t spmode_q;
    spi_pkg::reg_word_t spim_q;
    spi_pkg::reg_word_t spcom_q;
    spi_pkg::reg_word_t spie;
    spi_pkg::reg_word_t rd_mux;
    spi_pkg::reg_word_t rdata_q;
    logic               don_q;
    logic               start_q;
    logic               bvalid_q;
    logic               rvalid_q;
    logic               wr_fire;
    logic               wr_ok;
    logic               rd_fire;

    assign wr_fire = s_awvalid_i && s_wvalid_i && !bvalid_q;
    assign wr_ok   = wr_fire && (s_wstrb_i == 4'hf);  // full word writes only
    assign rd_fire = s_arvalid_i && !rvalid_q;

    assign s_awready_o = wr_fire;
    assign s_wready_o  = wr_fire;
    assign s_bvalid_o  = bvalid_q;
    assign s_bresp_o   = 2'b00;
    assign s_arready_o = !rvalid_q;
    assign s_rvalid_o  = rvalid_q;
    assign s_rdata_o   = rdata_q;
    assign s_rresp_o   = 2'b00;

    assign spmode_o      = spmode_q;
    assign spcom_o       = spcom_q;
    assign frame_start_o = start_q;
    assign txf_push_o    = wr_ok && (s_awaddr_i == `SPI_ADDR_SPITF);
    assign txf_data_o    = s_wdata_i;
    assign rxf_pop_o     = rd_fire && (s_araddr_i == `SPI_ADDR_SPIRF) && !rxf_empty_i;

    // sticky done plus live fifo flags
    always_comb begin
        spie            = '0;
        spie[`SPIE_DON] = don_q;
        spie[`SPIE_RNE] = !rxf_empty_i;
        spie[`SPIE_TNF] = !txf_full_i;
    end

    assign irq_o = |(spim_q & spie);

    always_comb begin
        case (s_araddr_i)
            `SPI_ADDR_SPMODE: rd_mux = spmode_q;
            `SPI_ADDR_SPIE:   rd_mux = spie;
            `SPI_ADDR_SPIM:   rd_mux = spim_q;
            `SPI_ADDR_SPCOM:  rd_mux = spcom_q;
            `SPI_ADDR_SPIRF:  rd_mux = rxf_empty_i ? '0 : {24'h0, rxf_data_i};
            default:          rd_mux = '0;
        endcase
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            spmode_q <= '0;
            spim_q   <= '0;
            spcom_q  <= '0;
            don_q    <= 1'b0;
            start_q  <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (wr_ok) begin
                case (s_awaddr_i)
                    `SPI_ADDR_SPMODE: spmode_q <= s_wdata_i;
                    `SPI_ADDR_SPIE: begin
                        if (s_wdata_i[`SPIE_DON]) begin
                            don_q <= 1'b0;
                        end
                    end
                    `SPI_ADDR_SPIM: spim_q <= s_wdata_i;
                    `SPI_ADDR_SPCOM: begin
                        if (!frame_busy_i) begin  // locked while a frame runs
                            spcom_q <= s_wdata_i;
                            start_q <= spmode_q[`SPMODE_EN];
                        end
                    end
                    default: ;
                endcase
            end
            if (frame_done_i) begin
                don_q <= 1'b1;  // set wins over clear
            end
        end
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid_q <= 1'b1;
            end else if (s_bready_i) begin
                bvalid_q <= 1'b0;
            end
            if (rd_fire) begin
                rvalid_q <= 1'b1;
            end else if (s_rready_i) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (rd_fire) begin
            rdata_q <= rd_mux;
        end
    end

endmodule

/* src/spi_frame_ctrl.sv */
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_frame_ctrl (
    input  logic                S_SYSCLK,
    input  logic                S_RESETN,
    input  logic                start_i,
    input  logic                cpha_i,
    input  logic                loop_i,
    input  spi_pkg::cs_idx_t    cs_idx_i,
    input  spi_pkg::xfer_len_t  tranlen_i,
    input  spi_pkg::reg_word_t  txf_data_i,
    input  logic                txf_empty_i,
    input  logic                lead_edge_i,
    input  logic                trail_edge_i,
    input  logic                miso_i,
    output logic                busy_o,
    output logic                done_o,
    output logic                txf_pop_o,
    output logic                rxf_push_o,
    output spi_pkg::spi_char_t  rxf_data_o,
    output logic                sck_run_o,
    output logic                mosi_o,
    output logic [`SPI_NCS-1:0] sel_o
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,    // waiting for a tx word
        ST_XFER,
        ST_FINISH
    } state_t;

    state_t              state_q;
    spi_pkg::xfer_len_t  len_q;
    spi_pkg::xfer_len_t  char_cnt_q;
    logic [1:0]          byte_idx_q;
    logic [3:0]          edge_cnt_q;  // sck edges in current char
    spi_pkg::spi_char_t  tx_sr_q;
    spi_pkg::spi_char_t  rx_sr_q;
    logic                push_q;
    logic [`SPI_NCS-1:0] sel_q;

    logic       din;
    logic       sample_e;
    logic       shift_e;
    logic       char_end;
    logic       last_char;
    logic       word_end;
    logic [1:0] next_idx;

    assign din       = loop_i ? tx_sr_q[7] : miso_i;
    assign sample_e  = cpha_i ? trail_edge_i : lead_edge_i;
    assign shift_e   = cpha_i ? lead_edge_i : trail_edge_i;
    // 16th edge is always a trailing one, sck back at idle
    assign char_end  = (state_q == ST_XFER) && trail_edge_i && (edge_cnt_q == 4'd15);
    assign last_char = (char_cnt_q == len_q);
    assign word_end  = (byte_idx_q == 2'd3) || last_char;
    assign next_idx  = byte_idx_q + 2'd1;

    assign busy_o     = (state_q != ST_IDLE);
    assign done_o     = (state_q == ST_FINISH);
    assign txf_pop_o  = char_end && word_end;
    assign sck_run_o  = (state_q == ST_XFER) && !(char_end && word_end);
    assign rxf_push_o = push_q;
    assign rxf_data_o = rx_sr_q;
    assign mosi_o     = tx_sr_q[7];
    assign sel_o      = sel_q;

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            state_q    <= ST_IDLE;
            len_q      <= '0;
            char_cnt_q <= '0;
            byte_idx_q <= '0;
            edge_cnt_q <= '0;
            push_q     <= 1'b0;
            sel_q      <= '1;
        end else begin
            push_q <= char_end;
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        len_q            <= tranlen_i;
                        char_cnt_q       <= '0;
                        byte_idx_q       <= '0;
                        sel_q[cs_idx_i]  <= 1'b0;
                        state_q          <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (!txf_empty_i) begin
                        edge_cnt_q <= '0;
                        state_q    <= ST_XFER;
                    end
                end
                ST_XFER: begin
                    if (lead_edge_i || trail_edge_i) begin
                        edge_cnt_q <= edge_cnt_q + 4'd1;
                    end
                    if (char_end) begin
                        char_cnt_q <= char_cnt_q + 1'b1;
                        if (last_char) begin
                            state_q <= ST_FINISH;
                        end else if (word_end) begin
                            byte_idx_q <= '0;  // next word from fifo
                            state_q    <= ST_WAIT;
                        end else begin
                            byte_idx_q <= next_idx;
                        end
                    end
                end
                ST_FINISH: begin
                    sel_q   <= '1;
                    state_q <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // msb first, bytes of a word low first
    always_ff @(posedge S_SYSCLK) begin
        if (state_q == ST_WAIT) begin
            tx_sr_q <= txf_data_i[8*byte_idx_q +: 8];
        end else if (char_end) begin
            tx_sr_q <= txf_data_i[8*next_idx +: 8];
        end else if (shift_e && (edge_cnt_q != 4'd0)) begin
            tx_sr_q <= {tx_sr_q[6:0], 1'b0};
        end
        if (sample_e) begin
            rx_sr_q <= {rx_sr_q[6:0], din};
        end
    end

endmodule

/* src/spi_clk_gen.sv */
`timescale 1ns/1ps

module spi_clk_gen (
    input  logic       S_SYSCLK,
    input  logic       S_RESETN,
    input  logic       run_i,
    input  logic       cpol_i,
    input  logic [7:0] prescale_i,
    output logic       sck_o,
    output logic       lead_edge_o,
    output logic       trail_edge_o
);
    logic [7:0] cnt_q;
    logic       sck_q;
    logic       lead_q;
    logic       trail_q;

    assign sck_o        = sck_q;
    assign lead_edge_o  = lead_q;
    assign trail_edge_o = trail_q;

    // half period is prescale_i + 1 sysclk cycles
    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            cnt_q   <= '0;
            sck_q   <= 1'b0;
            lead_q  <= 1'b0;
            trail_q <= 1'b0;
        end else if (!run_i) begin
            cnt_q   <= '0;
            sck_q   <= cpol_i;  // park at idle level
            lead_q  <= 1'b0;
            trail_q <= 1'b0;
        end else if (cnt_q == prescale_i) begin
            cnt_q   <= '0;
            sck_q   <= ~sck_q;
            lead_q  <= (sck_q == cpol_i);  // leaving idle level
            trail_q <= (sck_q != cpol_i);
        end else begin
            cnt_q   <= cnt_q + 8'd1;
            lead_q  <= 1'b0;
            trail_q <= 1'b0;
        end
    end

endmodule

/* src/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int  DEPTH = 4,
    parameter type T     = logic [7:0]
) (
    input  logic S_SYSCLK,
    input  logic S_RESETN,
    input  logic push_i,
    input  T     data_i,
    input  logic pop_i,
    output T     data_o,
    output logic full_o,
    output logic empty_o
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);
    localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;
    logic          do_push;
    logic          do_pop;

    assign do_push = push_i && !full_o;  // dropped when full
    assign do_pop  = pop_i && !empty_o;
    assign full_o  = (count_q == FULL_CNT);
    assign empty_o = (count_q == '0);
    assign data_o  = mem[rd_ptr_q];

    always_ff @(posedge S_SYSCLK) begin
        if (do_push) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

/* src/spi_pkg.sv */
package spi_pkg;

    typedef logic [31:0] reg_word_t;  // register and bus word
    typedef logic [7:0]  spi_char_t;
    typedef logic [7:0]  reg_addr_t;  // byte address
    typedef logic [15:0] xfer_len_t;  // characters minus one
    typedef logic [1:0]  cs_idx_t;

endpackage

/* src/spi_macros.svh */
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// register offsets
`define SPI_ADDR_SPMODE   8'h00
`define SPI_ADDR_SPIE     8'h04
`define SPI_ADDR_SPIM     8'h08
`define SPI_ADDR_SPCOM    8'h0C
`define SPI_ADDR_SPITF    8'h10
`define SPI_ADDR_SPIRF    8'h14

`define SPMODE_EN         0
`define SPMODE_LOOP       1
`define SPMODE_CPOL       2
`define SPMODE_CPHA       3
`define SPMODE_PM_HI      15
`define SPMODE_PM_LO      8

`define SPIE_DON          0   // sticky, write 1 to clear
`define SPIE_RNE          1
`define SPIE_TNF          2

`define SPCOM_CS_HI       31
`define SPCOM_CS_LO       30
`define SPCOM_TRANLEN_HI  15
`define SPCOM_TRANLEN_LO  0

`define SPI_NCS           4
`define SPI_TXFIFO_DEPTH  4   // words
`define SPI_RXFIFO_DEPTH  16  // characters

`endif
